//--- oooPkg.sv
package oooPkg;

    localparam int dataWidth = 32;
    localparam int numRegs = 8;
    localparam int regIdxWidth = 3;
    localparam int rsSize = 4;
    localparam int tagWidth = 3;
    localparam int opWidth = 3;
    localparam int slotWidth = $clog2(rsSize);
    localparam int shamtWidth = $clog2(dataWidth);
    localparam int adrWidth = 4;

    // tag k names station entry k-1
    localparam logic [tagWidth-1:0] tagFree = '0;

    // wishbone address map
    localparam logic [adrWidth-1:0] adrInst = 4'd0;
    localparam logic [adrWidth-1:0] adrRegBase = 4'd8;

    typedef enum logic [opWidth-1:0] {
        opAdd = 3'd0,
        opSub = 3'd1,
        opAnd = 3'd2,
        opOr  = 3'd3,
        opXor = 3'd4,
        opSll = 3'd5,
        opSrl = 3'd6,
        opSlt = 3'd7
    } aluOp_t;

    // low bits of the wishbone write data
    typedef struct packed {
        aluOp_t                 op;
        logic [regIdxWidth-1:0] rd;
        logic [regIdxWidth-1:0] rs1;
        logic [regIdxWidth-1:0] rs2;
    } instWord_t;

    typedef struct packed {
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;
    } operand_t;

    typedef struct packed {
        aluOp_t               op;
        operand_t             opO;
        operand_t             opT;
        logic [slotWidth-1:0] slot;
    } rsEntry_t;

    typedef struct packed {
        aluOp_t               op;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [tagWidth-1:0]  tag;
    } aluIssue_t;

    typedef struct packed {
        logic                 valid;
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;
    } cdbBus_t;

    function automatic logic [tagWidth-1:0] slotToTag(input logic [slotWidth-1:0] slot);
        return tagWidth'(slot) + tagWidth'(1);
    endfunction

    // resolve a waiting operand from this cycle's broadcast
    function automatic operand_t snoopOperand(input operand_t opnd, input cdbBus_t cdb);
        operand_t res;
        res = opnd;
        if (cdb.valid && opnd.tag != tagFree && opnd.tag == cdb.tag) begin
            res.tag = tagFree;
            res.data = cdb.data;
        end
        return res;
    endfunction

endpackage

//--- regRenameFile.sv
module regRenameFile
    import oooPkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [regIdxWidth-1:0] rdIdxO,
    input  logic [regIdxWidth-1:0] rdIdxT,
    input  logic [regIdxWidth-1:0] rdIdxW,
    input  logic                   renameEn,
    input  logic [regIdxWidth-1:0] renameIdx,
    input  logic [tagWidth-1:0]    renameTag,
    input  logic                   dirWrEn,
    input  logic [regIdxWidth-1:0] dirWrIdx,
    input  logic [dataWidth-1:0]   dirWrData,
    input  cdbBus_t                cdb,
    output operand_t               rdOpO,
    output operand_t               rdOpT,
    output operand_t               rdResult
);

    // value plus pending tag per register
    operand_t regs [numRegs];
    operand_t snooped [numRegs];

    // a tag matching this cycle's broadcast reads as already resolved
    always_comb begin
        for (int i = 0; i < numRegs; i++) begin
            snooped[i] = snoopOperand(regs[i], cdb);
        end
    end

    assign rdOpO = snooped[rdIdxO];
    assign rdOpT = snooped[rdIdxT];
    assign rdResult = snooped[rdIdxW];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i].tag <= tagFree;
                regs[i].data <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (dirWrEn && dirWrIdx == regIdxWidth'(i)) begin
                    regs[i].tag <= tagFree;
                    regs[i].data <= dirWrData;
                end else if (renameEn && renameIdx == regIdxWidth'(i)) begin
                    // newer rename wins over a broadcast of the old tag
                    regs[i].tag <= renameTag;
                end else begin
                    // only a still-matching tag takes the result, so WAW is safe
                    regs[i] <= snooped[i];
                end
            end
        end
    end

endmodule

//--- aluDispatcher.sv
module aluDispatcher
    import oooPkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wbCyc,
    input  logic                   wbStb,
    input  logic                   wbWe,
    input  logic [adrWidth-1:0]    wbAdr,
    input  logic [dataWidth-1:0]   wbDatW,
    input  operand_t               rdOpO,
    input  operand_t               rdOpT,
    input  operand_t               rdResult,
    input  logic [rsSize-1:0]      freeMask,
    output logic [dataWidth-1:0]   wbDatR,
    output logic                   wbAck,
    output logic [regIdxWidth-1:0] rdIdxO,
    output logic [regIdxWidth-1:0] rdIdxT,
    output logic [regIdxWidth-1:0] rdIdxW,
    output logic                   renameEn,
    output logic [regIdxWidth-1:0] renameIdx,
    output logic [tagWidth-1:0]    renameTag,
    output logic                   dirWrEn,
    output logic [regIdxWidth-1:0] dirWrIdx,
    output logic [dataWidth-1:0]   dirWrData,
    output logic                   rsWrite,
    output rsEntry_t               rsEntry
);

    instWord_t            inst;
    logic                 req;
    logic                 isInst;
    logic                 isReg;
    logic                 instGo;
    logic                 regWrGo;
    logic                 regRdGo;
    logic                 otherGo;
    logic [slotWidth-1:0] freeSlot;

    assign inst = instWord_t'(wbDatW[$bits(instWord_t)-1:0]);

    // the acked cycle must not be taken as a new strobe
    assign req = wbCyc && wbStb && !wbAck;
    assign isInst = wbAdr == adrInst;
    assign isReg = wbAdr >= adrRegBase;

    // stall while the station is full
    assign instGo = req && wbWe && isInst && (|freeMask);
    // direct writes wait for an idle station
    assign regWrGo = req && wbWe && isReg && (&freeMask);
    assign regRdGo = req && !wbWe && isReg && rdResult.tag == tagFree;
    assign otherGo = req && !isReg && !(isInst && wbWe);

    // lowest free slot
    always_comb begin
        freeSlot = '0;
        for (int i = rsSize - 1; i >= 0; i--) begin
            if (freeMask[i]) begin
                freeSlot = slotWidth'(i);
            end
        end
    end

    // operands are read before rd is renamed at the same edge
    assign rdIdxO = inst.rs1;
    assign rdIdxT = inst.rs2;
    assign rdIdxW = wbAdr[regIdxWidth-1:0];

    assign renameEn = instGo;
    assign renameIdx = inst.rd;
    assign renameTag = slotToTag(freeSlot);

    assign dirWrEn = regWrGo;
    assign dirWrIdx = wbAdr[regIdxWidth-1:0];
    assign dirWrData = wbDatW;

    assign rsWrite = instGo;
    assign rsEntry = '{op: inst.op, opO: rdOpO, opT: rdOpT, slot: freeSlot};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= instGo || regWrGo || regRdGo || otherGo;
        end
    end

    // anything but a register read returns zero
    always_ff @(posedge clk) begin
        wbDatR <= regRdGo ? rdResult.data : '0;
    end

endmodule

//--- aluResStation.sv
module aluResStation
    import oooPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              rsWrite,
    input  rsEntry_t          rsEntry,
    input  cdbBus_t           cdb,
    output logic [rsSize-1:0] freeMask,
    output logic              issueValid,
    output aluIssue_t         issue
);

    logic [rsSize-1:0]    entryValid;
    logic [rsSize-1:0]    inFlight;
    logic [rsSize-1:0]    cdbHit;
    logic [rsSize-1:0]    ready;
    logic [rsSize-1:0]    writeMask;
    logic [rsSize-1:0]    issueMask;
    logic                 anyReady;
    logic [slotWidth-1:0] pick;

    aluOp_t   entOp [rsSize];
    operand_t entO [rsSize];
    operand_t entT [rsSize];

    always_comb begin
        for (int i = 0; i < rsSize; i++) begin
            cdbHit[i] = cdb.valid && cdb.tag == slotToTag(slotWidth'(i));
            ready[i] = entryValid[i] && entO[i].tag == tagFree && entT[i].tag == tagFree;
        end
    end

    // lowest ready entry wins
    always_comb begin
        pick = '0;
        for (int i = rsSize - 1; i >= 0; i--) begin
            if (ready[i]) begin
                pick = slotWidth'(i);
            end
        end
    end

    assign anyReady = |ready;
    assign issueMask = anyReady ? (rsSize'(1) << pick) : '0;
    assign writeMask = rsWrite ? (rsSize'(1) << rsEntry.slot) : '0;

    // An issued entry is released at once, but its tag stays reserved until the
    // result is on the CDB. Reusing it earlier would let the old result land in
    // a register renamed to the new instruction.
    assign freeMask = ~entryValid & ~(inFlight & ~cdbHit);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            entryValid <= '0;
            inFlight <= '0;
            issueValid <= 1'b0;
        end else begin
            entryValid <= (entryValid & ~issueMask) | writeMask;
            inFlight <= (inFlight | issueMask) & ~cdbHit;
            issueValid <= anyReady;
        end
    end

    // wake-up also covers an operand broadcast in the write cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < rsSize; i++) begin
            if (writeMask[i]) begin
                entOp[i] <= rsEntry.op;
                entO[i] <= snoopOperand(rsEntry.opO, cdb);
                entT[i] <= snoopOperand(rsEntry.opT, cdb);
            end else begin
                entO[i] <= snoopOperand(entO[i], cdb);
                entT[i] <= snoopOperand(entT[i], cdb);
            end
        end
    end

    always_ff @(posedge clk) begin
        issue <= '{
            op: entOp[pick],
            a: entO[pick].data,
            b: entT[pick].data,
            tag: slotToTag(pick)
        };
    end

endmodule

//--- aluExecUnit.sv
module aluExecUnit
    import oooPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      issueValid,
    input  aluIssue_t issue,
    output cdbBus_t   cdb
);

    logic [dataWidth-1:0]  aluResult;
    logic [shamtWidth-1:0] shamt;
    logic                  lessThan;

    assign shamt = issue.b[shamtWidth-1:0];
    assign lessThan = $signed(issue.a) < $signed(issue.b);

    always_comb begin
        case (issue.op)
            opAdd: aluResult = issue.a + issue.b;
            opSub: aluResult = issue.a - issue.b;
            opAnd: aluResult = issue.a & issue.b;
            opOr: aluResult = issue.a | issue.b;
            opXor: aluResult = issue.a ^ issue.b;
            opSll: aluResult = issue.a << shamt;
            opSrl: aluResult = issue.a >> shamt;
            opSlt: aluResult = {{(dataWidth - 1){1'b0}}, lessThan};
            default: aluResult = '0;
        endcase
    end

    // the result register itself drives the CDB for one cycle
    always_ff @(posedge clk) begin
        cdb.tag <= issue.tag;
        cdb.data <= aluResult;
        if (!rstN) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issueValid;
        end
    end

endmodule

//--- oooCore.sv
module oooCore
    import oooPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [adrWidth-1:0]  wbAdr,
    input  logic [dataWidth-1:0] wbDatW,
    output logic [dataWidth-1:0] wbDatR,
    output logic                 wbAck
);

    logic [regIdxWidth-1:0] rdIdxO;
    logic [regIdxWidth-1:0] rdIdxT;
    logic [regIdxWidth-1:0] rdIdxW;
    operand_t               rdOpO;
    operand_t               rdOpT;
    operand_t               rdResult;
    logic                   renameEn;
    logic [regIdxWidth-1:0] renameIdx;
    logic [tagWidth-1:0]    renameTag;
    logic                   dirWrEn;
    logic [regIdxWidth-1:0] dirWrIdx;
    logic [dataWidth-1:0]   dirWrData;
    logic [rsSize-1:0]      freeMask;
    logic                   rsWrite;
    rsEntry_t               rsEntry;
    logic                   issueValid;
    aluIssue_t              issue;
    cdbBus_t                cdb;

    aluDispatcher dispatcher_i (
        .clk       (clk),
        .rstN      (rstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .rdOpO     (rdOpO),
        .rdOpT     (rdOpT),
        .rdResult  (rdResult),
        .freeMask  (freeMask),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .rdIdxO    (rdIdxO),
        .rdIdxT    (rdIdxT),
        .rdIdxW    (rdIdxW),
        .renameEn  (renameEn),
        .renameIdx (renameIdx),
        .renameTag (renameTag),
        .dirWrEn   (dirWrEn),
        .dirWrIdx  (dirWrIdx),
        .dirWrData (dirWrData),
        .rsWrite   (rsWrite),
        .rsEntry   (rsEntry)
    );

    regRenameFile regFile_i (
        .clk       (clk),
        .rstN      (rstN),
        .rdIdxO    (rdIdxO),
        .rdIdxT    (rdIdxT),
        .rdIdxW    (rdIdxW),
        .renameEn  (renameEn),
        .renameIdx (renameIdx),
        .renameTag (renameTag),
        .dirWrEn   (dirWrEn),
        .dirWrIdx  (dirWrIdx),
        .dirWrData (dirWrData),
        .cdb       (cdb),
        .rdOpO     (rdOpO),
        .rdOpT     (rdOpT),
        .rdResult  (rdResult)
    );

    aluResStation resStation_i (
        .clk        (clk),
        .rstN       (rstN),
        .rsWrite    (rsWrite),
        .rsEntry    (rsEntry),
        .cdb        (cdb),
        .freeMask   (freeMask),
        .issueValid (issueValid),
        .issue      (issue)
    );

    aluExecUnit execUnit_i (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .issue      (issue),
        .cdb        (cdb)
    );

endmodule

//--- oooCoreAssertions.sv
module oooCoreAssertions
    import oooPkg::*;
(
    input logic              clk,
    input logic              rstN,
    input logic              wbCyc,
    input logic              wbStb,
    input logic              wbAck,
    input cdbBus_t           cdb,
    input logic [rsSize-1:0] freeMask
);
    timeunit 1ns;
    timeprecision 100ps;

    ackInCycle: assert property (@(posedge clk) disable iff (!rstN)
        wbAck |-> wbCyc && wbStb)
        else $error("wbAck outside an active bus cycle");

    // one ack per strobe
    ackSingle: assert property (@(posedge clk) disable iff (!rstN)
        wbAck |=> !wbAck)
        else $error("wbAck high for two cycles in a row");

    cdbTagValid: assert property (@(posedge clk) disable iff (!rstN)
        cdb.valid |-> cdb.tag != tagFree)
        else $error("CDB broadcast carries the free tag");

    stationIdleAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> &freeMask)
        else $error("station not empty after reset");

endmodule

bind oooCore oooCoreAssertions assertions_i (
    .clk      (clk),
    .rstN     (rstN),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbAck    (wbAck),
    .cdb      (cdb),
    .freeMask (freeMask)
);

//--- oooCoreTb.sv
module oooCoreTb
    import oooPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // the tests need under 1500 cycles
    localparam int testCycles = 1500;
    localparam int cycleLimit = testCycles * 8 / 3;

    logic                 clk;
    logic                 rstN;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [adrWidth-1:0]  wbAdr;
    logic [dataWidth-1:0] wbDatW;
    logic [dataWidth-1:0] wbDatR;
    logic                 wbAck;

    // expected architectural state in program order
    logic [dataWidth-1:0] refRegs [numRegs];
    logic [31:0]          lfsrState;
    int                   cycleCount = 0;
    int                   checkCount;
    int                   errorCount;
    int                   testCount;

    oooCore oooCore_i (
        .clk    (clk),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [dataWidth-1:0] randomBits(input int count);
        logic [dataWidth-1:0] value;
        logic                 feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value = {value[dataWidth-2:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [dataWidth-1:0] expectedResult(input aluOp_t op,
            input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
        case (op)
            opAdd: return a + b;
            opSub: return a - b;
            opAnd: return a & b;
            opOr: return a | b;
            opXor: return a ^ b;
            opSll: return a << b[4:0];
            opSrl: return a >> b[4:0];
            opSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [dataWidth-1:0] actual,
            input logic [dataWidth-1:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // holds the request until ack and through the ack cycle
    task automatic wbTransfer(input logic we, input logic [adrWidth-1:0] adr,
            input logic [dataWidth-1:0] wdata, output logic [dataWidth-1:0] rdata);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = wdata;
        do @(negedge clk); while (!wbAck);
        rdata = wbDatR;
        @(negedge clk);
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic writeReg(input logic [regIdxWidth-1:0] idx, input logic [dataWidth-1:0] data);
        logic [dataWidth-1:0] unused;
        wbTransfer(1'b1, adrRegBase | adrWidth'(idx), data, unused);
        refRegs[idx] = data;
    endtask

    task automatic issueInst(input aluOp_t op, input logic [regIdxWidth-1:0] rd,
            input logic [regIdxWidth-1:0] rs1, input logic [regIdxWidth-1:0] rs2);
        instWord_t            word;
        logic [dataWidth-1:0] unused;
        word = '{op: op, rd: rd, rs1: rs1, rs2: rs2};
        wbTransfer(1'b1, adrInst, dataWidth'(word), unused);
        refRegs[rd] = expectedResult(op, refRegs[rs1], refRegs[rs2]);
    endtask

    task automatic checkReg(input logic [regIdxWidth-1:0] idx);
        logic [dataWidth-1:0] value;
        wbTransfer(1'b0, adrRegBase | adrWidth'(idx), '0, value);
        compareValue($sformatf("wbDatR reg[%0d]", idx), value, refRegs[idx]);
    endtask

    task automatic verifyRegisterFile();
        for (int i = 0; i < numRegs; i++) begin
            checkReg(regIdxWidth'(i));
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        end
    endtask

    task automatic resetAndDirectAccess();
        int                   errorsBefore;
        logic [dataWidth-1:0] value;
        errorsBefore = errorCount;
        verifyRegisterFile();
        for (int i = 0; i < numRegs; i++) begin
            writeReg(regIdxWidth'(i), randomBits(dataWidth));
        end
        // unmapped addresses ack, read zero and ignore writes
        wbTransfer(1'b1, 4'd5, 32'hffff_ffff, value);
        wbTransfer(1'b0, 4'd3, '0, value);
        compareValue("wbDatR unmapped", value, '0);
        verifyRegisterFile();
        reportTest("reset and direct access", errorsBefore);
    endtask

    task automatic eachOpcode();
        int errorsBefore;
        errorsBefore = errorCount;
        writeReg(3'd1, 32'h8000_00f3);
        writeReg(3'd2, 32'h0000_0005);
        writeReg(3'd3, 32'h7fff_0000);
        for (int i = 0; i < 8; i++) begin
            issueInst(aluOp_t'(i), regIdxWidth'(4 + i % 4), 3'd1, 3'd2);
            checkReg(regIdxWidth'(4 + i % 4));
        end
        // positive against negative gives zero
        issueInst(opSlt, 3'd5, 3'd3, 3'd1);
        checkReg(3'd5);
        reportTest("each opcode", errorsBefore);
    endtask

    task automatic dependentChain();
        int errorsBefore;
        errorsBefore = errorCount;
        writeReg(3'd1, 32'h0000_0003);
        writeReg(3'd2, 32'h1111_1111);
        issueInst(opAdd, 3'd3, 3'd1, 3'd2);
        issueInst(opSll, 3'd4, 3'd3, 3'd1);
        issueInst(opXor, 3'd5, 3'd4, 3'd3);
        issueInst(opSub, 3'd6, 3'd5, 3'd2);
        issueInst(opOr, 3'd3, 3'd6, 3'd3);
        issueInst(opSlt, 3'd7, 3'd3, 3'd6);
        issueInst(opAnd, 3'd1, 3'd7, 3'd3);
        issueInst(opSrl, 3'd2, 3'd3, 3'd1);
        verifyRegisterFile();
        reportTest("dependent chain", errorsBefore);
    endtask

    task automatic randomBurst();
        int                   errorsBefore;
        logic [dataWidth-1:0] fields;
        errorsBefore = errorCount;
        for (int i = 0; i < 40; i++) begin
            fields = randomBits(12);
            issueInst(aluOp_t'(fields[11:9]), fields[8:6], fields[5:3], fields[2:0]);
        end
        verifyRegisterFile();
        reportTest("random burst", errorsBefore);
    endtask

    task automatic readAfterPending();
        int errorsBefore;
        errorsBefore = errorCount;
        writeReg(3'd1, 32'h0000_00ff);
        writeReg(3'd2, 32'h0000_0004);
        // read goes out while the result is still pending
        issueInst(opSll, 3'd3, 3'd1, 3'd2);
        checkReg(3'd3);
        issueInst(opAdd, 3'd4, 3'd3, 3'd3);
        issueInst(opSub, 3'd5, 3'd4, 3'd1);
        issueInst(opXor, 3'd6, 3'd5, 3'd4);
        writeReg(3'd6, 32'hdead_beef);
        verifyRegisterFile();
        reportTest("read and write after pending", errorsBefore);
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        lfsrState = 32'd79916;
        checkCount = 0;
        errorCount = 0;
        testCount = 0;
        for (int i = 0; i < numRegs; i++) begin
            refRegs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        resetAndDirectAccess();
        eachOpcode();
        dependentChain();
        randomBurst();
        readAfterPending();

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
oooPkg.sv
regRenameFile.sv
aluDispatcher.sv
aluResStation.sv
aluExecUnit.sv
oooCore.sv
oooCoreAssertions.sv
oooCoreTb.sv

//--- Makefile
TOP := oooCoreTb

.PHONY: run clean

obj_dir/V$(TOP): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o V$(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
